// ==== bench/map_219_vectors.txt ====
# op test addr(hex) value(hex): W and S write the value, P C R Q M E check it
# A pulses A12 with map_sub = value, E checks {ram_ce, ram_we} on a write cycle
P 1 8123 18123
P 1 A456 1A456
P 1 C789 1C789
P 1 FFFF 1FFFF
C 1 0123 00123
C 1 07FF 007FF
C 1 1C55 01C55
Q 1 0000 0
R 1 007F DB
R 1 0028 0C
R 1 0030 FF
W 2 8002 25
W 2 8001 3C
P 2 A000 1E000
W 2 8002 26
W 2 8001 08
P 2 8000 08000
P 2 C000 1C000
R 2 0029 0F
W 3 8000 0A
W 3 8001 05
W 3 8000 0B
W 3 8001 14
C 3 0655 16E55
W 3 8000 14
W 3 8001 0B
C 3 1655 15655
C 3 0000 00000
R 3 002D 05
R 3 002E 01
M 4 2400 1
M 4 2800 0
W 4 A000 01
M 4 2400 0
M 4 2800 1
E 4 6000 0
W 4 A001 80
E 4 6000 3
E 4 7FFF 3
E 4 5FFF 0
W 4 A001 C0
E 4 6000 2
W 5 C000 02
W 5 C001 00
W 5 E001 00
A 5 1000 0
Q 5 0000 0
A 5 1000 0
Q 5 0000 0
A 5 1000 0
Q 5 0000 1
W 5 E000 00
Q 5 0000 0
W 5 C000 00
W 5 E001 00
A 5 1000 4
Q 5 0000 0
A 5 1000 0
Q 5 0000 1
W 5 E000 00
Q 5 0000 0
S 6 0003 A5
S 6 0021 6C
S 6 0029 09
W 6 A000 00
W 6 8002 26
R 6 0003 A5
R 6 0021 6C
R 6 0029 09
R 6 0008 14
M 6 2400 0
P 6 A000 12000

// ==== tb.f ====
+incdir+src
src/bus_pkg.sv
src/map_pkg.sv
src/irq_mmc3.sv
src/mmc3_regs.sv
src/ext_banks.sv
src/map_out_mux.sv
src/map_219.sv
bench/tb_map_219.sv

// ==== Bender.yml ====
package:
  name: map_219

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bus_pkg.sv
      - src/map_pkg.sv
      - src/irq_mmc3.sv
      - src/mmc3_regs.sv
      - src/ext_banks.sv
      - src/map_out_mux.sv
      - src/map_219.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_map_219.sv

// ==== bench/tb_map_219.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module tb_map_219 import bus_pkg::*; import map_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int SETTLE = 2; // combinational outputs are sampled this long after the drive edge
	localparam string VEC_FILE = "bench/map_219_vectors.txt";

	logic m2;
	logic map_rst;
	cpu_addr_t cpu_addr;
	byte_t cpu_dat;
	logic cpu_rw;
	ppu_addr_t ppu_addr;
	logic ppu_oe;
	logic ppu_we;
	logic [`MAP_SUB_W-1:0] map_sub;
	logic cfg_mir_v;
	logic cfg_chr_ram;
	logic ss_act;
	logic ss_we;
	ss_addr_t ss_addr;
	logic [`PRG_ADDR_W-1:0] prg_addr;
	logic [`CHR_ADDR_W-1:0] chr_addr;
	logic [`SRM_ADDR_W-1:0] srm_addr;
	logic ciram_a10;
	logic ciram_ce;
	logic ram_ce;
	logic ram_we;
	logic rom_ce;
	logic prg_oe;
	logic chr_oe;
	logic chr_ce;
	logic chr_we;
	logic irq;
	byte_t ss_rdat;

	logic [7:0] vec_op [$];
	int vec_test [$];
	logic [15:0] vec_addr [$];
	logic [31:0] vec_dat [$];
	bit vec_ready = 1'b0;

	int cur_test = 0;
	int n_checks = 0;
	int n_errs = 0;
	int test_checks = 0;
	int test_errs = 0;

	map_219 u_dut (
		.m2 (m2), .map_rst (map_rst), .cpu_addr (cpu_addr), .cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .ppu_oe (ppu_oe), .ppu_we (ppu_we),
		.map_sub (map_sub), .cfg_mir_v (cfg_mir_v), .cfg_chr_ram (cfg_chr_ram),
		.ss_act (ss_act), .ss_we (ss_we), .ss_addr (ss_addr),
		.prg_addr (prg_addr), .chr_addr (chr_addr), .srm_addr (srm_addr),
		.ciram_a10 (ciram_a10), .ciram_ce (ciram_ce), .ram_ce (ram_ce), .ram_we (ram_we),
		.rom_ce (rom_ce), .prg_oe (prg_oe), .chr_oe (chr_oe), .chr_ce (chr_ce),
		.chr_we (chr_we), .irq (irq), .ss_rdat (ss_rdat)
	);

	initial
	begin
		m2 = 1'b0;
		forever #(CLK_PERIOD/2) m2 = ~m2;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ helpers
	task automatic drive_idle(input logic keep_ss);
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_rw = 1'b1;
		ppu_addr = '0; // A12 low between operations
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		ss_we = 1'b0;
		ss_addr = '0;
		if (!keep_ss)
			ss_act = 1'b0;
	endtask

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		test_checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %0t: test %0d %s expected %h got %h", $time, cur_test, what, exp, got);
			n_errs++;
			test_errs++;
		end
	endtask

	// expected {chr_ce, ciram_ce, chr_oe, chr_we} for one PPU cycle
	function automatic logic [3:0] ppu_strobes(input logic [13:0] addr, input bit rd,
		input bit wr);
		bit pattern;
		pattern = (addr < 14'h2000); // pattern tables fill the space below the nametables
		return {pattern, pattern, rd, wr && cfg_chr_ram};
	endfunction

	task automatic report_test();
		$display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errs);
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic load_vectors(output bit ok);
		int fd;
		int code;
		bit done;
		bit bad;
		logic [7:0] op;
		int tnum;
		logic [15:0] addr;
		logic [31:0] dat;
		logic [8*128-1:0] line_buf;
		ok = 1'b0;
		bad = 1'b0;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
			$display("cannot open the vectors file %s", VEC_FILE);
		else
		begin
			done = 1'b0;
			while (!done)
			begin
				code = $fscanf(fd, " %c", op);
				if (code != 1)
					done = 1'b1;
				else if (op == "#")
					code = $fgets(line_buf, fd);
				else
				begin
					code = $fscanf(fd, " %d %h %h", tnum, addr, dat);
					if (code != 3)
					begin
						$display("malformed line in the vectors file after %0d vectors", vec_op.size());
						bad = 1'b1;
						done = 1'b1;
					end
					else
					begin
						vec_op.push_back(op);
						vec_test.push_back(tnum);
						vec_addr.push_back(addr);
						vec_dat.push_back(dat);
					end
				end
			end
			$fclose(fd);
			ok = !bad && (vec_op.size() > 0);
			if (!bad && vec_op.size() == 0)
				$display("the vectors file holds no vectors");
		end
	endtask

	// one operation starts on a falling edge and ends before the next one
	task automatic run_vector(input logic [7:0] op, input logic [15:0] addr,
		input logic [31:0] dat);
		@(negedge m2);
		drive_idle(op == "S" || op == "W"); // ss_act stays up across S and W lines
		case (op)
			"W":
			begin
				cpu_addr = addr;
				cpu_dat = dat[7:0];
				cpu_rw = 1'b0;
			end
			"S":
			begin
				ss_act = 1'b1;
				ss_we = 1'b1;
				ss_addr = addr[7:0];
				cpu_dat = dat[7:0];
			end
			"P":
			begin
				cpu_addr = addr;
				#SETTLE;
				check_val("prg_addr", prg_addr, dat);
				check_val("rom_ce/prg_oe", {rom_ce, prg_oe}, {addr >= 16'h8000, 1'b1});
			end
			"C":
			begin
				ppu_addr = addr[13:0];
				ppu_oe = 1'b0;
				#SETTLE;
				check_val("chr_addr", chr_addr, dat);
				check_val("chr_ce/ciram_ce/chr_oe/chr_we", {chr_ce, ciram_ce, chr_oe, chr_we},
					ppu_strobes(addr[13:0], 1'b1, 1'b0));
			end
			"R":
			begin
				ss_addr = addr[7:0];
				#SETTLE check_val("ss_rdat", ss_rdat, dat);
			end
			"A":
			begin
				map_sub = dat[`MAP_SUB_W-1:0];
				repeat (3) @(posedge m2);
				@(negedge m2);
				ppu_addr = addr[13:0]; // high through one rising edge
			end
			"Q":
				#SETTLE check_val("irq", irq, dat);
			"M":
			begin
				ppu_addr = addr[13:0];
				ppu_we = 1'b0; // nametable write cycle
				#SETTLE;
				check_val("ciram_a10", ciram_a10, dat);
				check_val("chr_ce/ciram_ce/chr_oe/chr_we", {chr_ce, ciram_ce, chr_oe, chr_we},
					ppu_strobes(addr[13:0], 1'b0, 1'b1));
			end
			"E":
			begin
				cpu_addr = addr;
				cpu_rw = 1'b0;
				#SETTLE;
				check_val("ram_ce/ram_we", {ram_ce, ram_we}, dat);
				check_val("rom_ce/prg_oe", {rom_ce, prg_oe}, {addr >= 16'h8000, 1'b0});
				check_val("srm_addr", srm_addr, addr % 16'h2000); // offset in the 8 KB RAM page
			end
			default:
			begin
				$display("unknown opcode %c in the vectors file", op);
				n_errs++;
				test_errs++;
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ main sequence
	initial
	begin : main
		bit ok;
		drive_idle(1'b0);
		map_sub = '0;
		cfg_mir_v = 1'b1; // powers up in vertical mirroring
		cfg_chr_ram = 1'b1; // CHR-RAM board so PPU writes strobe the CHR chip
		map_rst = 1'b1;
		load_vectors(ok);
		if (!ok)
		begin
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			vec_ready = 1'b1;
			repeat (2) @(posedge m2);
			@(negedge m2);
			map_rst = 1'b0;
			for (int i = 0; i < vec_op.size(); i++)
			begin
				if (vec_test[i] != cur_test)
				begin
					if (cur_test != 0)
						report_test();
					cur_test = vec_test[i];
				end
				run_vector(vec_op[i], vec_addr[i], vec_dat[i]);
			end
			report_test();
			@(negedge m2);
			$display("%0d vectors, %0d checks, %0d errors", vec_op.size(), n_checks, n_errs);
			if (n_errs == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin : watchdog
		wait (vec_ready);
		repeat (vec_op.size() * 20) @(posedge m2);
		$display("watchdog expired after %0d cycles without the run ending", vec_op.size() * 20);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/map_219.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module map_219 import bus_pkg::*; import map_pkg::*;
(
	input  wire                    m2,
	input  wire                    map_rst,
	input  wire cpu_addr_t         cpu_addr,
	input  wire byte_t             cpu_dat,
	input  wire                    cpu_rw,
	input  wire ppu_addr_t         ppu_addr,
	input  wire                    ppu_oe,
	input  wire                    ppu_we,
	input  wire [`MAP_SUB_W-1:0]   map_sub,
	input  wire                    cfg_mir_v,
	input  wire                    cfg_chr_ram,
	input  wire                    ss_act,
	input  wire                    ss_we,
	input  wire ss_addr_t          ss_addr,
	output logic [`PRG_ADDR_W-1:0] prg_addr,
	output logic [`CHR_ADDR_W-1:0] chr_addr,
	output logic [`SRM_ADDR_W-1:0] srm_addr,
	output logic                   ciram_a10,
	output logic                   ciram_ce,
	output logic                   ram_ce,
	output logic                   ram_we,
	output logic                   rom_ce,
	output logic                   prg_oe,
	output logic                   chr_oe,
	output logic                   chr_ce,
	output logic                   chr_we,
	output logic                   irq,
	output byte_t                  ss_rdat
);

	logic mir_mod;
	logic ram_we_off;
	logic ram_ce_on;
	byte_t mmc3_ss_dat;
	ext_prg_t prg_bank;
	byte_t chr_bank;
	byte_t ext_ss_dat;

	mmc3_regs u_mmc3 (
		.m2 (m2), .map_rst (map_rst), .cpu_addr (cpu_addr), .cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .map_sub (map_sub), .cfg_mir_v (cfg_mir_v),
		.ss_act (ss_act), .ss_we (ss_we), .ss_addr (ss_addr),
		.mir_mod (mir_mod), .ram_we_off (ram_we_off), .ram_ce_on (ram_ce_on),
		.irq (irq), .mmc3_ss_dat (mmc3_ss_dat)
	);

	ext_banks u_ext (
		.m2 (m2), .map_rst (map_rst), .cpu_addr (cpu_addr), .cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .ss_act (ss_act), .ss_we (ss_we),
		.ss_addr (ss_addr), .prg_bank (prg_bank), .chr_bank (chr_bank),
		.ext_ss_dat (ext_ss_dat)
	);

	map_out_mux u_mux (
		.cpu_addr (cpu_addr), .cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .ppu_oe (ppu_oe),
		.ppu_we (ppu_we), .cfg_chr_ram (cfg_chr_ram), .ss_addr (ss_addr),
		.mir_mod (mir_mod), .ram_we_off (ram_we_off), .ram_ce_on (ram_ce_on),
		.prg_bank (prg_bank), .chr_bank (chr_bank), .mmc3_ss_dat (mmc3_ss_dat),
		.ext_ss_dat (ext_ss_dat), .prg_addr (prg_addr), .chr_addr (chr_addr),
		.srm_addr (srm_addr), .ciram_a10 (ciram_a10), .ciram_ce (ciram_ce),
		.ram_ce (ram_ce), .ram_we (ram_we), .rom_ce (rom_ce), .prg_oe (prg_oe),
		.chr_oe (chr_oe), .chr_ce (chr_ce), .chr_we (chr_we), .ss_rdat (ss_rdat)
	);

endmodule

`default_nettype wire

// ==== src/map_out_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module map_out_mux import bus_pkg::*; import map_pkg::*;
(
	input  wire cpu_addr_t         cpu_addr,
	input  wire                    cpu_rw,
	input  wire ppu_addr_t         ppu_addr,
	input  wire                    ppu_oe,
	input  wire                    ppu_we,
	input  wire                    cfg_chr_ram,
	input  wire ss_addr_t          ss_addr,
	input  wire                    mir_mod,
	input  wire                    ram_we_off,
	input  wire                    ram_ce_on,
	input  wire ext_prg_t          prg_bank,
	input  wire byte_t             chr_bank,
	input  wire byte_t             mmc3_ss_dat,
	input  wire byte_t             ext_ss_dat,
	output logic [`PRG_ADDR_W-1:0] prg_addr,
	output logic [`CHR_ADDR_W-1:0] chr_addr,
	output logic [`SRM_ADDR_W-1:0] srm_addr,
	output logic                   ciram_a10,
	output logic                   ciram_ce,
	output logic                   ram_ce,
	output logic                   ram_we,
	output logic                   rom_ce,
	output logic                   prg_oe,
	output logic                   chr_oe,
	output logic                   chr_ce,
	output logic                   chr_we,
	output byte_t                  ss_rdat
);

	localparam int PRG_PAD = `PRG_ADDR_W - `EXT_PRG_W - 13;
	localparam ss_addr_t SS_IRQ = `SS_ADDR_IRQ;

	logic mmc_hit;
	logic ext_hit;

	assign prg_addr = {{PRG_PAD{1'b0}}, prg_bank, cpu_addr[12:0]};
	assign chr_addr = {chr_bank, ppu_addr[9:0]};
	assign srm_addr = cpu_addr[`SRM_ADDR_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ strobes
	assign ram_ce = (cpu_addr[15:13] == 3'b011) && ram_ce_on;
	assign ram_we = !cpu_rw && ram_ce && !ram_we_off;
	assign rom_ce = cpu_addr[15];
	assign prg_oe = cpu_rw;
	assign chr_oe = !ppu_oe;
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce = ciram_ce;
	assign chr_we = cfg_chr_ram && !ppu_we;
	assign ciram_a10 = mir_mod ? ppu_addr[11] : ppu_addr[10]; // A10 for vertical

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ save-state readback
	assign mmc_hit = (ss_addr <= `SS_ADDR_MMC_CTRL1) || (ss_addr[7:3] == SS_IRQ[7:3]);
	assign ext_hit = (ss_addr >= `SS_ADDR_EXT_CHR) && (ss_addr <= `SS_ADDR_SET_FLAGS);

	always_comb
	begin
		if (mmc_hit)
			ss_rdat = mmc3_ss_dat;
		else if (ext_hit)
			ss_rdat = ext_ss_dat;
		else if (ss_addr == `SS_ADDR_IDX)
			ss_rdat = `MAP_IDX;
		else
			ss_rdat = 8'hFF; // unmapped slots read as open bus
	end

endmodule

`default_nettype wire

// ==== src/ext_banks.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module ext_banks import bus_pkg::*; import map_pkg::*;
(
	input  wire            m2,
	input  wire            map_rst,
	input  wire cpu_addr_t cpu_addr,
	input  wire byte_t     cpu_dat,
	input  wire            cpu_rw,
	input  wire ppu_addr_t ppu_addr,
	input  wire            ss_act,
	input  wire            ss_we,
	input  wire ss_addr_t  ss_addr,
	output ext_prg_t       prg_bank,
	output byte_t          chr_bank,
	output byte_t          ext_ss_dat
);

	localparam ss_addr_t SS_CHR = `SS_ADDR_EXT_CHR;
	localparam ss_addr_t SS_PRG = `SS_ADDR_EXT_PRG;

	ext_prg_t ext_prg [4];
	byte_t ext_chr [8];
	byte_t ext_reg_sel;
	logic [3:0] chr_sel;
	logic set_prg;
	logic set_chr;
	logic [15:0] ext_reg_addr;
	ext_dat_u ext_dat;
	ext_prg_t prg_rev;
	logic chr_win;
	logic prg_win;

	assign ext_reg_addr = cpu_addr & 16'hE003;
	assign ext_dat.raw = cpu_dat;
	assign prg_rev = {ext_dat.prg.bank_rev[0], ext_dat.prg.bank_rev[1],
		ext_dat.prg.bank_rev[2], ext_dat.prg.bank_rev[3]}; // D2 lands on the top bit

	assign chr_win = (ss_addr[7:3] == SS_CHR[7:3]);
	assign prg_win = (ss_addr[7:2] == SS_PRG[7:2]);

	assign prg_bank = ext_prg[cpu_addr[14:13]];
	assign chr_bank = ext_chr[ppu_addr[12:10]];

	always_ff @(posedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && chr_win)
				ext_chr[ss_addr[2:0]] <= cpu_dat;
			if (ss_we && prg_win)
				ext_prg[ss_addr[1:0]] <= cpu_dat[`EXT_PRG_W-1:0];
			if (ss_we && ss_addr == `SS_ADDR_EXT_SEL)
				ext_reg_sel <= cpu_dat;
			if (ss_we && ss_addr == `SS_ADDR_CHR_SEL)
				chr_sel <= cpu_dat[3:0];
			if (ss_we && ss_addr == `SS_ADDR_SET_FLAGS)
				{set_prg, set_chr} <= cpu_dat[1:0];
		end
		else if (map_rst)
		begin
			ext_prg[0] <= `EXT_PRG_RST_0;
			ext_prg[1] <= `EXT_PRG_RST_1;
			ext_prg[2] <= `EXT_PRG_RST_2;
			ext_prg[3] <= `EXT_PRG_RST_3;
			ext_chr[0] <= `EXT_CHR_RST_0;
			ext_chr[1] <= `EXT_CHR_RST_1;
			ext_chr[2] <= `EXT_CHR_RST_2;
			ext_chr[3] <= `EXT_CHR_RST_3;
			ext_chr[4] <= `EXT_CHR_RST_4;
			ext_chr[5] <= `EXT_CHR_RST_5;
			ext_chr[6] <= `EXT_CHR_RST_6;
			ext_chr[7] <= `EXT_CHR_RST_7;
			ext_reg_sel <= '0;
			chr_sel <= '0;
			set_prg <= 1'b0;
			set_chr <= 1'b0;
		end
		else if (!cpu_rw)
		begin
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ selector writes
			if (ext_reg_addr == 16'h8000)
			begin
				ext_reg_sel <= cpu_dat;
				set_prg <= 1'b0;
				set_chr <= 1'b1;
			end
			if (ext_reg_addr == 16'h8002)
			begin
				ext_reg_sel <= cpu_dat;
				set_prg <= 1'b1;
				set_chr <= 1'b0;
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ data writes
			if (ext_reg_addr == 16'h8001 && set_prg)
			begin
				case (ext_reg_sel)
					8'h26: ext_prg[0] <= prg_rev;
					8'h25: ext_prg[1] <= prg_rev;
					8'h24: ext_prg[2] <= prg_rev;
					8'h23: ext_prg[3] <= prg_rev;
					default: ;
				endcase
			end
			if (ext_reg_addr == 16'h8001 && set_chr)
			begin
				case (ext_reg_sel)
					8'h08, 8'h0A, 8'h0E, 8'h12, 8'h16, 8'h1A, 8'h1E:
						chr_sel <= cpu_dat[3:0]; // high nibble for the next bank writes
					8'h09: ext_chr[0] <= {chr_sel, ext_dat.chr.bank_1k, 1'b0};
					8'h0B: ext_chr[1] <= {chr_sel, ext_dat.chr.bank_1k, 1'b1};
					8'h0C, 8'h0D: ext_chr[2] <= {chr_sel, ext_dat.chr.bank_1k, 1'b0};
					8'h0F: ext_chr[3] <= {chr_sel, ext_dat.chr.bank_1k, 1'b1};
					8'h10, 8'h11:
						ext_chr[4] <= {chr_sel, ext_dat.chr.bank_1k, ext_dat.chr.bank_2k_lo};
					8'h14, 8'h15:
						ext_chr[5] <= {chr_sel, ext_dat.chr.bank_1k, ext_dat.chr.bank_2k_lo};
					8'h18, 8'h19:
						ext_chr[6] <= {chr_sel, ext_dat.chr.bank_1k, ext_dat.chr.bank_2k_lo};
					8'h1C, 8'h1D:
						ext_chr[7] <= {chr_sel, ext_dat.chr.bank_1k, ext_dat.chr.bank_2k_lo};
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		if (chr_win)
			ext_ss_dat = ext_chr[ss_addr[2:0]];
		else if (prg_win)
			ext_ss_dat = {{(`BYTE_W-`EXT_PRG_W){1'b0}}, ext_prg[ss_addr[1:0]]};
		else if (ss_addr == `SS_ADDR_EXT_SEL)
			ext_ss_dat = ext_reg_sel;
		else if (ss_addr == `SS_ADDR_CHR_SEL)
			ext_ss_dat = {4'd0, chr_sel};
		else if (ss_addr == `SS_ADDR_SET_FLAGS)
			ext_ss_dat = {6'd0, set_prg, set_chr};
		else
			ext_ss_dat = '0;
	end

	a_one_mode: assert property (@(posedge m2) disable iff (map_rst)
		!(set_prg && set_chr));

endmodule

`default_nettype wire

// ==== src/mmc3_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module mmc3_regs import bus_pkg::*; import map_pkg::*;
(
	input  wire                  m2,
	input  wire                  map_rst,
	input  wire cpu_addr_t       cpu_addr,
	input  wire byte_t           cpu_dat,
	input  wire                  cpu_rw,
	input  wire ppu_addr_t       ppu_addr,
	input  wire [`MAP_SUB_W-1:0] map_sub,
	input  wire                  cfg_mir_v,
	input  wire                  ss_act,
	input  wire                  ss_we,
	input  wire ss_addr_t        ss_addr,
	output logic                 mir_mod,
	output logic                 ram_we_off,
	output logic                 ram_ce_on,
	output logic                 irq,
	output byte_t                mmc3_ss_dat
);

	localparam logic [63:0] BANK_RST = `BANK_DAT_RST;

	byte_t bank_sel;
	byte_t bank_dat [8];
	byte_t mmc_ctrl0;
	byte_t mmc_ctrl1;
	byte_t irq_ss_dat;
	logic [15:0] reg_addr;
	logic mmc3a;

	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]}; // only A15-A13 and A0 decode
	assign mmc3a = (map_sub == `MMC3A_SUB);

	assign mir_mod = mmc_ctrl0[0];
	assign ram_we_off = mmc_ctrl1[6];
	assign ram_ce_on = mmc_ctrl1[7];

	always_ff @(posedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && ss_addr < `SS_ADDR_BANK_SEL)
				bank_dat[ss_addr[2:0]] <= cpu_dat;
			if (ss_we && ss_addr == `SS_ADDR_BANK_SEL)
				bank_sel <= cpu_dat;
			if (ss_we && ss_addr == `SS_ADDR_MMC_CTRL0)
				mmc_ctrl0 <= cpu_dat;
			if (ss_we && ss_addr == `SS_ADDR_MMC_CTRL1)
				mmc_ctrl1 <= cpu_dat;
		end
		else if (map_rst)
		begin
			bank_sel <= '0;
			mmc_ctrl0 <= {7'd0, !cfg_mir_v}; // board solder pad picks the power-on mirroring
			mmc_ctrl1 <= '0;
			for (int i = 0; i < 8; i++)
				bank_dat[i] <= BANK_RST[i*8 +: 8];
		end
		else if (!cpu_rw)
		begin
			case (reg_addr)
				16'h8000: bank_sel <= cpu_dat;
				16'h8001: bank_dat[bank_sel[2:0]] <= cpu_dat;
				16'hA000: mmc_ctrl0 <= cpu_dat;
				16'hA001: mmc_ctrl1 <= cpu_dat;
				default: ;
			endcase
		end
	end

	irq_mmc3 u_irq (
		.m2         (m2),
		.map_rst    (map_rst),
		.cpu_addr   (cpu_addr),
		.cpu_dat    (cpu_dat),
		.cpu_rw     (cpu_rw),
		.ppu_addr   (ppu_addr),
		.mmc3a      (mmc3a),
		.ss_act     (ss_act),
		.ss_we      (ss_we),
		.ss_addr    (ss_addr),
		.irq        (irq),
		.irq_ss_dat (irq_ss_dat)
	);

	always_comb
	begin
		if (ss_addr < `SS_ADDR_BANK_SEL)
			mmc3_ss_dat = bank_dat[ss_addr[2:0]];
		else if (ss_addr == `SS_ADDR_BANK_SEL)
			mmc3_ss_dat = bank_sel;
		else if (ss_addr == `SS_ADDR_MMC_CTRL0)
			mmc3_ss_dat = mmc_ctrl0;
		else if (ss_addr == `SS_ADDR_MMC_CTRL1)
			mmc3_ss_dat = mmc_ctrl1;
		else
			mmc3_ss_dat = irq_ss_dat; // zero outside the IRQ window
	end

	// data must be settled by the sampling edge of every write strobe
	a_dat_known: assert property (@(posedge m2) disable iff (map_rst)
		(!cpu_rw || (ss_act && ss_we)) |-> !$isunknown(cpu_dat));

endmodule

`default_nettype wire

// ==== src/irq_mmc3.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "map_219_config.svh"

module irq_mmc3 import bus_pkg::*;
(
	input  wire               m2,
	input  wire               map_rst,
	input  wire cpu_addr_t    cpu_addr,
	input  wire [`BYTE_W-1:0] cpu_dat,
	input  wire               cpu_rw,
	input  wire ppu_addr_t    ppu_addr,
	input  wire               mmc3a,
	input  wire               ss_act,
	input  wire               ss_we,
	input  wire ss_addr_t     ss_addr,
	output logic              irq,
	output logic [`BYTE_W-1:0] irq_ss_dat
);

	localparam logic [1:0] A12_LOW_MIN = 2'd3;
	localparam ss_addr_t SS_IRQ = `SS_ADDR_IRQ;

	logic [`BYTE_W-1:0] irq_latch;
	logic [`BYTE_W-1:0] irq_ctr;
	logic [`BYTE_W-1:0] ctr_nxt;
	logic irq_on;
	logic irq_pend;
	logic reload_req;
	logic [1:0] a12_low_cnt;
	logic [15:0] reg_addr;
	logic a12_clk;
	logic irq_set;
	logic irq_win;

	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]};
	assign irq_win = (ss_addr[7:3] == SS_IRQ[7:3]);

	// a rise counts only after A12 sat low long enough to rule out pattern fetch jitter
	assign a12_clk = ppu_addr[12] && (a12_low_cnt == A12_LOW_MIN);
	assign ctr_nxt = (irq_ctr == '0 || reload_req) ? irq_latch : irq_ctr - 1'b1;

	// MMC3A does not fire again while the counter sits at zero
	assign irq_set = a12_clk && irq_on && (ctr_nxt == '0) &&
		(!mmc3a || irq_ctr != '0 || reload_req);

	assign irq = irq_pend;

	always_ff @(posedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && irq_win)
			begin
				case (ss_addr[2:0])
					3'd0: irq_latch <= cpu_dat;
					3'd1: irq_ctr <= cpu_dat;
					3'd2: {reload_req, irq_on, irq_pend} <= cpu_dat[2:0];
					3'd3: a12_low_cnt <= cpu_dat[1:0];
					default: ;
				endcase
			end
		end
		else if (map_rst)
		begin
			irq_latch <= '0;
			irq_ctr <= '0;
			irq_on <= 1'b0;
			irq_pend <= 1'b0;
			reload_req <= 1'b0;
			a12_low_cnt <= '0;
		end
		else
		begin
			if (ppu_addr[12])
				a12_low_cnt <= '0;
			else if (a12_low_cnt != A12_LOW_MIN)
				a12_low_cnt <= a12_low_cnt + 2'd1;

			if (a12_clk)
			begin
				irq_ctr <= ctr_nxt;
				reload_req <= 1'b0;
			end
			if (irq_set)
				irq_pend <= 1'b1;

			// register writes land after the counter update so they win a collision
			if (!cpu_rw)
			begin
				case (reg_addr)
					16'hC000: irq_latch <= cpu_dat;
					16'hC001:
					begin
						irq_ctr <= '0;
						reload_req <= 1'b1;
					end
					16'hE000:
					begin
						irq_on <= 1'b0;
						irq_pend <= 1'b0; // disable also acknowledges
					end
					16'hE001: irq_on <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		irq_ss_dat = '0;
		if (irq_win)
		begin
			case (ss_addr[2:0])
				3'd0: irq_ss_dat = irq_latch;
				3'd1: irq_ss_dat = irq_ctr;
				3'd2: irq_ss_dat = {5'd0, reload_req, irq_on, irq_pend};
				3'd3: irq_ss_dat = {6'd0, a12_low_cnt};
				default: ;
			endcase
		end
	end

	a_irq_needs_on: assert property (@(posedge m2) disable iff (map_rst)
		$rose(irq) |-> irq_on);

endmodule

`default_nettype wire

// ==== src/map_pkg.sv ====
`default_nettype none

`include "map_219_config.svh"

package map_pkg;

	typedef logic [`BYTE_W-1:0] byte_t;
	typedef logic [`EXT_PRG_W-1:0] ext_prg_t;

	// the byte written to the extension data port
	typedef union packed {
		byte_t raw;
		struct packed {
			logic [1:0] pad_hi;
			logic [3:0] bank_rev; // stored bit-reversed into the PRG slot
			logic [1:0] pad_lo;
		} prg;
		struct packed {
			logic [2:0] pad_hi;
			logic [2:0] bank_1k;
			logic       bank_2k_lo; // low bit of a 2 KB bank number
			logic       pad_lo;
		} chr;
	} ext_dat_u;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

`include "map_219_config.svh"

package bus_pkg;

	// console side of the cartridge edge
	typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [`PPU_ADDR_W-1:0] ppu_addr_t;

	// save-state port, one byte register per address
	typedef logic [`SS_ADDR_W-1:0] ss_addr_t;

endpackage

`default_nettype wire

// ==== src/map_219_config.svh ====
`ifndef MAP_219_CONFIG_SVH
`define MAP_219_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ widths
`define CPU_ADDR_W        16
`define PPU_ADDR_W        14
`define SS_ADDR_W         8
`define BYTE_W            8
`define EXT_PRG_W         4
`define MAP_SUB_W         3
`define PRG_ADDR_W        19
`define CHR_ADDR_W        18
`define SRM_ADDR_W        13

`define MAP_IDX           8'd219
`define MMC3A_SUB         3'd4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ power-on banks
`define BANK_DAT_RST      64'h01_00_07_06_05_04_02_00 // slot 7 in the top byte
`define EXT_PRG_RST_0     4'hC
`define EXT_PRG_RST_1     4'hD
`define EXT_PRG_RST_2     4'hE
`define EXT_PRG_RST_3     4'hF
`define EXT_CHR_RST_0     8'd0
`define EXT_CHR_RST_1     8'd1
`define EXT_CHR_RST_2     8'd2
`define EXT_CHR_RST_3     8'd3
`define EXT_CHR_RST_4     8'd4
`define EXT_CHR_RST_5     8'd5
`define EXT_CHR_RST_6     8'd6
`define EXT_CHR_RST_7     8'd7

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ save-state map
`define SS_ADDR_BANK_DAT  8'd0
`define SS_ADDR_BANK_SEL  8'd8
`define SS_ADDR_MMC_CTRL0 8'd9
`define SS_ADDR_MMC_CTRL1 8'd10
`define SS_ADDR_IRQ       8'd16
`define SS_ADDR_EXT_CHR   8'd32
`define SS_ADDR_EXT_PRG   8'd40
`define SS_ADDR_EXT_SEL   8'd44
`define SS_ADDR_CHR_SEL   8'd45
`define SS_ADDR_SET_FLAGS 8'd46
`define SS_ADDR_IDX       8'd127

`endif
